/* verilog/noc_pkg.sv */
// flit layout and counts for one spidergon node; networks of at most 8 nodes, 2 vcs per port
package noc_pkg;

	localparam int NUM_VC = 2; // virtual channels per port
	localparam int VC_W = (NUM_VC > 1) ? $clog2(NUM_VC) : 1;
	localparam int NUM_RING_PORTS = 3; // anticlockwise, clockwise, across
	localparam int NODE_ID_W = 3; // node number width
	localparam int PAYLOAD_W = 9; // data bits per flit

	// flit kind codes
	typedef enum logic [1:0]
	{
		kind_tail = 2'b00,
		kind_head = 2'b01,
		kind_body = 2'b10,
		kind_header = 2'b11 // single-flit packet that allocates and frees in one go
	} flit_kind_t;

	// output direction with ring ports first so they double as array indices
	typedef enum logic [1:0]
	{
		port_anticlockwise = 2'd0,
		port_clockwise = 2'd1,
		port_across = 2'd2,
		port_local = 2'd3 // ejection to the cpu
	} port_t;

	// 18 bit flit whose dest only matters on head and header flits
	typedef struct packed
	{
		flit_kind_t kind;
		logic [VC_W-1:0] vc; // vc at the receiving input port
		logic [NODE_ID_W-1:0] dest;
		logic [NODE_ID_W-1:0] src;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

endpackage

/* verilog/switch_if.sv */
// buffer bank to controller link; dequeue may only be raised on a vc whose empty flag is low
`timescale 1ns/100ps

interface switch_if;
	import noc_pkg::*;

	flit_t head_flit [NUM_VC]; // oldest flit of each vc fifo
	logic [NUM_VC-1:0] empty; // fifo holds nothing
	logic [NUM_VC-1:0] dequeue; // pop that fifo at the next edge

	// input buffer side
	modport buffer
	(
		output head_flit,
		output empty,
		input dequeue
	);

	// allocation and arbitration side
	modport control
	(
		input head_flit,
		input empty,
		output dequeue
	);

endinterface

/* verilog/vc_buffer_bank.sv */
// input fifos for one ring port; upstream must respect credits, a write into a full fifo is lost
`timescale 1ns/100ps

module vc_buffer_bank
#(
	parameter int BUFFER_DEPTH = 2 // at least 1 entry per vc
)
(
	input logic clk,
	input logic reset,
	input noc_pkg::flit_t in_flit,
	input logic in_valid,
	output logic [noc_pkg::NUM_VC-1:0] in_credit, // one pulse per dequeue back to upstream
	switch_if.buffer sw
);
	import noc_pkg::*;

	localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	// circular pointer step
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	for (genvar v = 0; v < NUM_VC; v++)
	begin : g_vc
		flit_t mem [BUFFER_DEPTH]; // fifo storage
		logic [PTR_W-1:0] wr_ptr;
		logic [PTR_W-1:0] rd_ptr;
		logic [CNT_W-1:0] count; // entries held
		logic wr_en;
		logic rd_en;

		assign wr_en = in_valid && (in_flit.vc == VC_W'(v)); // vc field picks the fifo
		assign rd_en = sw.dequeue[v];

		always_ff @(posedge clk)
		begin
			if (wr_en)
				mem[wr_ptr] <= in_flit;
		end

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (wr_en)
					wr_ptr <= next_ptr(wr_ptr);
				if (rd_en)
					rd_ptr <= next_ptr(rd_ptr);
				if (wr_en && !rd_en)
					count <= count + 1'b1;
				else if (!wr_en && rd_en)
					count <= count - 1'b1; // push and pop together leave count alone
			end
		end

		assign sw.head_flit[v] = mem[rd_ptr]; // front of queue while not empty
		assign sw.empty[v] = (count == '0);
	end

	// credit back upstream one cycle after the pop
	always_ff @(posedge clk)
	begin
		if (reset)
			in_credit <= '0;
		else
			in_credit <= sw.dequeue;
	end

endmodule

/* verilog/node_control.sv */
// vc allocation and switch arbitration; dest must be below NUM_NODES, cpu ejection never stalls
`timescale 1ns/100ps

module node_control
#(
	parameter int NUM_NODES = 8, // 4 or 8
	parameter int NODE_ID = 0
)
(
	input logic clk,
	input logic reset,
	input logic [noc_pkg::NUM_VC-1:0] has_credit [noc_pkg::NUM_RING_PORTS], // per ring output
	switch_if.control sw_acw,
	switch_if.control sw_cw,
	switch_if.control sw_across,
	output logic [noc_pkg::NUM_RING_PORTS-1:0] send,
	output noc_pkg::flit_t send_flit [noc_pkg::NUM_RING_PORTS],
	output noc_pkg::flit_t cpu_flit,
	output logic cpu_valid
);
	import noc_pkg::*;

	localparam int NUM_IN = NUM_RING_PORTS * NUM_VC; // input vcs indexed by port*NUM_VC + vc
	localparam int NUM_OUT = NUM_RING_PORTS + 1; // ring outputs plus local
	localparam int IDX_W = $clog2(NUM_IN);

	flit_t head [NUM_IN]; // front flits of all input vcs
	logic [NUM_IN-1:0] empty;
	logic [NUM_IN-1:0] dequeue;

	logic [NUM_IN-1:0] req; // input vc wants its port this cycle
	port_t req_port [NUM_IN];
	logic [VC_W-1:0] req_vc [NUM_IN]; // output vc it would use

	port_t alloc_port [NUM_IN]; // allocation table written by granted heads
	logic [VC_W-1:0] alloc_vc [NUM_IN];
	logic [NUM_VC-1:0] busy [NUM_RING_PORTS]; // output vc owned by an open packet

	logic [IDX_W-1:0] rr_ptr [NUM_OUT]; // round-robin start per output
	logic [NUM_OUT-1:0] gnt_any;
	logic [IDX_W-1:0] gnt_idx [NUM_OUT];

	// relative distance picks the ring quarter
	function automatic port_t route(input logic [NODE_ID_W-1:0] dest);
		int rel;
		rel = (int'(dest) - NODE_ID + NUM_NODES) % NUM_NODES;
		if (rel == 0)
			return port_local;
		else if (rel <= NUM_NODES / 4)
			return port_clockwise;
		else if (rel >= 3 * NUM_NODES / 4)
			return port_anticlockwise;
		else
			return port_across;
	endfunction

	// gather the three banks in port_t order
	for (genvar v = 0; v < NUM_VC; v++)
	begin : g_gather
		assign head[v] = sw_acw.head_flit[v];
		assign head[NUM_VC + v] = sw_cw.head_flit[v];
		assign head[2 * NUM_VC + v] = sw_across.head_flit[v];
	end
	assign empty = {sw_across.empty, sw_cw.empty, sw_acw.empty};
	assign sw_acw.dequeue = dequeue[0 +: NUM_VC];
	assign sw_cw.dequeue = dequeue[NUM_VC +: NUM_VC];
	assign sw_across.dequeue = dequeue[2 * NUM_VC +: NUM_VC];

	// request per input vc
	always_comb
	begin : requests
		logic [NUM_VC-1:0] free;
		for (int i = 0; i < NUM_IN; i++)
		begin
			free = '0;
			req_vc[i] = '0;
			if (head[i].kind inside {kind_head, kind_header})
			begin
				req_port[i] = route(head[i].dest);
				if (req_port[i] == port_local)
					req[i] = !empty[i]; // cpu always takes it
				else
				begin
					free = ~busy[req_port[i]] & has_credit[req_port[i]];
					for (int v = NUM_VC - 1; v >= 0; v--)
					begin
						if (free[v])
							req_vc[i] = VC_W'(v); // lowest free vc wins
					end
					req[i] = !empty[i] && (|free);
				end
			end
			else
			begin
				// body and tail follow the head's allocation
				req_port[i] = alloc_port[i];
				req_vc[i] = alloc_vc[i];
				req[i] = !empty[i] &&
					((alloc_port[i] == port_local) || has_credit[alloc_port[i]][alloc_vc[i]]);
			end
		end
	end

	// one round-robin arbiter per output searching from rr_ptr
	always_comb
	begin : arbiters
		int idx;
		for (int o = 0; o < NUM_OUT; o++)
		begin
			gnt_any[o] = 1'b0;
			gnt_idx[o] = '0;
			for (int k = 0; k < NUM_IN; k++)
			begin
				idx = (int'(rr_ptr[o]) + k) % NUM_IN;
				if (!gnt_any[o] && req[idx] && (req_port[idx] == port_t'(o)))
				begin
					gnt_any[o] = 1'b1;
					gnt_idx[o] = IDX_W'(idx);
				end
			end
		end
	end

	// each input asks for one output only so it never pops twice
	always_comb
	begin
		dequeue = '0;
		for (int o = 0; o < NUM_OUT; o++)
		begin
			if (gnt_any[o])
				dequeue[gnt_idx[o]] = 1'b1;
		end
	end

	// crossbar to the ring outputs with vc rewritten to the output allocation
	always_comb
	begin
		for (int o = 0; o < NUM_RING_PORTS; o++)
		begin
			send[o] = gnt_any[o];
			send_flit[o] = head[gnt_idx[o]];
			send_flit[o].vc = req_vc[gnt_idx[o]];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int o = 0; o < NUM_OUT; o++)
				rr_ptr[o] <= '0;
			for (int p = 0; p < NUM_RING_PORTS; p++)
				busy[p] <= '0;
			cpu_valid <= 1'b0;
		end
		else
		begin
			for (int o = 0; o < NUM_OUT; o++)
			begin
				if (gnt_any[o]) // move just past the winner
					rr_ptr[o] <= (gnt_idx[o] == IDX_W'(NUM_IN - 1)) ? '0 : gnt_idx[o] + 1'b1;
			end
			for (int i = 0; i < NUM_IN; i++)
			begin
				if (dequeue[i] && (req_port[i] != port_local))
				begin
					if (head[i].kind == kind_head)
						busy[req_port[i]][req_vc[i]] <= 1'b1; // open packet
					else if (head[i].kind == kind_tail)
						busy[req_port[i]][req_vc[i]] <= 1'b0; // header never marks it
				end
			end
			cpu_valid <= gnt_any[port_local];
		end
	end

	// allocation table and cpu output register
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_IN; i++)
		begin
			if (dequeue[i] && (head[i].kind == kind_head))
			begin
				alloc_port[i] <= req_port[i];
				alloc_vc[i] <= req_vc[i];
			end
		end
		if (gnt_any[port_local])
			cpu_flit <= head[gnt_idx[port_local]]; // vc left as received
	end

endmodule

/* verilog/output_channel.sv */
// one ring output; credit counters start full at reset and expect at most one return per flit
`timescale 1ns/100ps

module output_channel
#(
	parameter int BUFFER_DEPTH = 2 // downstream fifo entries per vc
)
(
	input logic clk,
	input logic reset,
	input logic send,
	input noc_pkg::flit_t send_flit, // vc already the output vc
	input logic [noc_pkg::NUM_VC-1:0] out_credit, // returns from downstream
	output logic [noc_pkg::NUM_VC-1:0] has_credit,
	output noc_pkg::flit_t out_flit,
	output logic out_valid
);
	import noc_pkg::*;

	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	logic [CNT_W-1:0] credit_cnt [NUM_VC]; // free slots downstream
	logic [NUM_VC-1:0] take; // flit leaves on that vc

	always_comb
	begin
		for (int v = 0; v < NUM_VC; v++)
		begin
			take[v] = send && (send_flit.vc == VC_W'(v));
			has_credit[v] = (credit_cnt[v] != '0);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int v = 0; v < NUM_VC; v++)
				credit_cnt[v] <= CNT_W'(BUFFER_DEPTH);
			out_valid <= 1'b0;
		end
		else
		begin
			for (int v = 0; v < NUM_VC; v++)
			begin
				if (take[v] && !out_credit[v])
					credit_cnt[v] <= credit_cnt[v] - 1'b1;
				else if (!take[v] && out_credit[v])
					credit_cnt[v] <= credit_cnt[v] + 1'b1; // both at once cancel
			end
			out_valid <= send; // single cycle strobe
		end
	end

	always_ff @(posedge clk)
	begin
		if (send)
			out_flit <= send_flit;
	end

endmodule

/* verilog/spidergon_node.sv */
// spidergon node top; credit flow control on all ring ports, no cpu injection, cpu side never stalls
`timescale 1ns/100ps

module spidergon_node
#(
	parameter int NUM_NODES = 8,
	parameter int NODE_ID = 0,
	parameter int BUFFER_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input noc_pkg::flit_t in_flit_acw,
	input logic in_valid_acw,
	output logic [noc_pkg::NUM_VC-1:0] in_credit_acw,
	input noc_pkg::flit_t in_flit_cw,
	input logic in_valid_cw,
	output logic [noc_pkg::NUM_VC-1:0] in_credit_cw,
	input noc_pkg::flit_t in_flit_across,
	input logic in_valid_across,
	output logic [noc_pkg::NUM_VC-1:0] in_credit_across,
	output noc_pkg::flit_t out_flit_acw,
	output logic out_valid_acw,
	input logic [noc_pkg::NUM_VC-1:0] out_credit_acw,
	output noc_pkg::flit_t out_flit_cw,
	output logic out_valid_cw,
	input logic [noc_pkg::NUM_VC-1:0] out_credit_cw,
	output noc_pkg::flit_t out_flit_across,
	output logic out_valid_across,
	input logic [noc_pkg::NUM_VC-1:0] out_credit_across,
	output noc_pkg::flit_t cpu_flit,
	output logic cpu_valid
);
	import noc_pkg::*;

	logic [NUM_VC-1:0] has_credit [NUM_RING_PORTS]; // indexed by port_t
	logic [NUM_RING_PORTS-1:0] send;
	flit_t send_flit [NUM_RING_PORTS];

	switch_if sw_acw_if ();
	switch_if sw_cw_if ();
	switch_if sw_across_if ();

	// input side, one bank per incoming link
	vc_buffer_bank #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_bank_acw (.clk(clk), .reset(reset),
		.in_flit(in_flit_acw), .in_valid(in_valid_acw), .in_credit(in_credit_acw),
		.sw(sw_acw_if.buffer));
	vc_buffer_bank #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_bank_cw (.clk(clk), .reset(reset),
		.in_flit(in_flit_cw), .in_valid(in_valid_cw), .in_credit(in_credit_cw),
		.sw(sw_cw_if.buffer));
	vc_buffer_bank #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_bank_across (.clk(clk), .reset(reset),
		.in_flit(in_flit_across), .in_valid(in_valid_across), .in_credit(in_credit_across),
		.sw(sw_across_if.buffer));

	node_control #(.NUM_NODES(NUM_NODES), .NODE_ID(NODE_ID)) i_node_control (.clk(clk),
		.reset(reset), .has_credit(has_credit), .sw_acw(sw_acw_if.control),
		.sw_cw(sw_cw_if.control), .sw_across(sw_across_if.control), .send(send),
		.send_flit(send_flit), .cpu_flit(cpu_flit), .cpu_valid(cpu_valid));

	// output side in port_t order
	output_channel #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_out_acw (.clk(clk), .reset(reset),
		.send(send[port_anticlockwise]), .send_flit(send_flit[port_anticlockwise]),
		.out_credit(out_credit_acw), .has_credit(has_credit[port_anticlockwise]),
		.out_flit(out_flit_acw), .out_valid(out_valid_acw));
	output_channel #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_out_cw (.clk(clk), .reset(reset),
		.send(send[port_clockwise]), .send_flit(send_flit[port_clockwise]),
		.out_credit(out_credit_cw), .has_credit(has_credit[port_clockwise]),
		.out_flit(out_flit_cw), .out_valid(out_valid_cw));
	output_channel #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_out_across (.clk(clk), .reset(reset),
		.send(send[port_across]), .send_flit(send_flit[port_across]),
		.out_credit(out_credit_across), .has_credit(has_credit[port_across]),
		.out_flit(out_flit_across), .out_valid(out_valid_across));

endmodule

/* dv/spidergon_node_assertions.sv */
// credit checks for every output_channel; counter checks are off while reset is high
`timescale 1ns/100ps

module spidergon_node_assertions
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input logic send,
	input noc_pkg::flit_t send_flit,
	input logic [noc_pkg::NUM_VC-1:0] has_credit,
	input logic [$clog2(BUFFER_DEPTH + 1)-1:0] credit_cnt [noc_pkg::NUM_VC],
	input logic out_valid
);
	import noc_pkg::*;

	// a flit only leaves on a vc with a free slot downstream
	no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
		send |-> has_credit[send_flit.vc])
		else $error("flit sent on output vc %0d without credit", send_flit.vc);

	for (genvar v = 0; v < NUM_VC; v++)
	begin : g_cnt
		credit_in_range: assert property (@(posedge clk) disable iff (reset)
			int'(credit_cnt[v]) <= BUFFER_DEPTH)
			else $error("credit counter of vc %0d above buffer depth", v);
	end

	out_valid_low_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

endmodule

bind output_channel spidergon_node_assertions #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_credit_assertions
(
	.clk(clk),
	.reset(reset),
	.send(send),
	.send_flit(send_flit),
	.has_credit(has_credit),
	.credit_cnt(credit_cnt),
	.out_valid(out_valid)
);

/* dv/spidergon_node_tb.sv */
// testbench for node 0 of 8 with 2-deep buffers; random wormhole packets on all three ring inputs
`timescale 1ns/100ps

module spidergon_node_tb;
	import noc_pkg::*;

	localparam int NUM_NODES = 8;
	localparam int NODE_ID = 0;
	localparam int BUFFER_DEPTH = 2;
	localparam int NUM_PKTS = 40; // packets per source
	localparam int NUM_TAGS = NUM_RING_PORTS * NUM_VC; // src tag = port*2 + vc
	localparam int FREE = 7; // owner value of an idle output vc
	localparam int LIMIT = NUM_RING_PORTS * NUM_PKTS * 40 + 2000; // watchdog cycles

	logic clk = 1'b0;
	logic reset;
	flit_t in_flit [NUM_RING_PORTS]; // 0 acw, 1 cw, 2 across
	logic in_valid [NUM_RING_PORTS];
	logic [NUM_VC-1:0] in_credit [NUM_RING_PORTS];
	flit_t out_flit [NUM_RING_PORTS];
	logic out_valid [NUM_RING_PORTS];
	logic [NUM_VC-1:0] out_credit [NUM_RING_PORTS];
	flit_t cpu_flit;
	logic cpu_valid;

	int seed = 32'h8b83_717e;
	flit_t exp_q [4 * NUM_TAGS][$]; // expected flits, index port*NUM_TAGS + src tag
	int sent [NUM_TAGS]; // flits sent per input vc
	int returned [NUM_TAGS]; // in_credit pulses per input vc
	int owner [NUM_RING_PORTS][NUM_VC] = '{default: FREE}; // tag of the open packet
	int due [NUM_TAGS][$]; // credit release cycles per output vc
	int rx_stalled [NUM_TAGS]; // flits seen while the sink holds credits back
	int cycle = 0;

	always #4 clk = ~clk;

	spidergon_node #(.NUM_NODES(NUM_NODES), .NODE_ID(NODE_ID), .BUFFER_DEPTH(BUFFER_DEPTH))
		i_spidergon_node
	(
		.clk(clk),
		.reset(reset),
		.in_flit_acw(in_flit[0]),
		.in_valid_acw(in_valid[0]),
		.in_credit_acw(in_credit[0]),
		.in_flit_cw(in_flit[1]),
		.in_valid_cw(in_valid[1]),
		.in_credit_cw(in_credit[1]),
		.in_flit_across(in_flit[2]),
		.in_valid_across(in_valid[2]),
		.in_credit_across(in_credit[2]),
		.out_flit_acw(out_flit[0]),
		.out_valid_acw(out_valid[0]),
		.out_credit_acw(out_credit[0]),
		.out_flit_cw(out_flit[1]),
		.out_valid_cw(out_valid[1]),
		.out_credit_cw(out_credit[1]),
		.out_flit_across(out_flit[2]),
		.out_valid_across(out_valid[2]),
		.out_credit_across(out_credit[2]),
		.cpu_flit(cpu_flit),
		.cpu_valid(cpu_valid)
	);

	// reference routing: 1..2 hops clockwise, 6..7 anticlockwise, the rest across
	function automatic int expected_port(input int dest);
		int rel;
		rel = (dest - NODE_ID + NUM_NODES) % NUM_NODES;
		if (rel == 0)
			return 3; // cpu
		else if (rel <= NUM_NODES / 4)
			return 1;
		else if (rel >= 3 * NUM_NODES / 4)
			return 0;
		else
			return 2;
	endfunction

	// staggered 30 cycle credit stall per sink, once every 180 cycles
	function automatic logic withholding(input int port, input int at);
		return ((at + 60 * port) % 180) >= 150;
	endfunction

	function automatic int queued_flits();
		int total;
		total = 0;
		for (int i = 0; i < 4 * NUM_TAGS; i++)
			total += exp_q[i].size();
		return total;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR: %s expected %0h actual %0h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// compare one output flit with the oldest one queued for its port and tag
	task automatic take_flit(input int port, input flit_t got);
		int idx;
		flit_t want;
		flit_t seen;
		seen = got;
		seen.vc = '0; // output vc checked by ownership instead
		idx = port * NUM_TAGS + int'(got.src);
		if (int'(got.src) >= NUM_TAGS || exp_q[idx].size() == 0)
		begin
			$display("flit %h came out on port %0d but no such flit was sent", got, port);
			$display("STATUS: FAIL");
			$fatal(1, "unexpected flit");
		end
		else
		begin
			want = exp_q[idx].pop_front();
			want.vc = '0;
			check_value("routing and order", 32'(want), 32'(seen));
		end
	endtask

	// one open packet per output vc, all its flits on that vc
	task automatic track_vc(input int port, input flit_t got);
		int tag;
		tag = int'(got.src);
		case (got.kind)
			kind_head, kind_header:
			begin
				check_value("output vc free at head", FREE, owner[port][got.vc]);
				if (got.kind == kind_head)
					owner[port][got.vc] = tag;
			end
			default:
			begin
				check_value("output vc of open packet", tag, owner[port][got.vc]);
				if (got.kind == kind_tail)
					owner[port][got.vc] = FREE; // packet closed
			end
		endcase
	endtask

	// packets for one input port, sent only while a credit is held
	task automatic run_source(input int port);
		int s;
		int nflits;
		int slot;
		flit_t f;
		s = seed + port; // own random stream
		for (int k = 0; k < NUM_PKTS; k++)
		begin
			f.vc = VC_W'($unsigned($random(s)) % NUM_VC);
			f.dest = NODE_ID_W'($unsigned($random(s)) % NUM_NODES);
			f.src = NODE_ID_W'(port * NUM_VC + int'(f.vc)); // stream tag
			nflits = (($random(s) & 3) == 0) ? 1 : 2 + int'($unsigned($random(s)) % 4);
			slot = port * NUM_VC + int'(f.vc);
			for (int n = 0; n < nflits; n++)
			begin
				if (nflits == 1)
					f.kind = kind_header;
				else if (n == 0)
					f.kind = kind_head;
				else if (n == nflits - 1)
					f.kind = kind_tail;
				else
					f.kind = kind_body;
				f.payload = PAYLOAD_W'($unsigned($random(s)));
				do
				begin
					@(posedge clk);
					#1;
					in_valid[port] = 1'b0;
				end
				while (BUFFER_DEPTH + returned[slot] - sent[slot] <= 0);
				in_flit[port] = f;
				in_valid[port] = 1'b1;
				sent[slot]++;
				exp_q[expected_port(int'(f.dest)) * NUM_TAGS + int'(f.src)].push_back(f);
			end
		end
		@(posedge clk);
		#1;
		in_valid[port] = 1'b0;
	endtask

	// count credit pulses from the DUT
	always @(posedge clk)
	begin
		for (int p = 0; p < NUM_RING_PORTS; p++)
			for (int v = 0; v < NUM_VC; v++)
				if (in_credit[p][v])
					returned[p * NUM_VC + v]++;
	end

	// sinks and compare process
	initial
	begin : sinks
		int slot;
		int release_at;
		for (int p = 0; p < NUM_RING_PORTS; p++)
			out_credit[p] = '0;
		forever
		begin
			@(posedge clk); // outputs are registered, stable here
			for (int p = 0; p < NUM_RING_PORTS; p++)
			begin
				if (out_valid[p])
				begin
					slot = p * NUM_VC + int'(out_flit[p].vc);
					take_flit(p, out_flit[p]);
					track_vc(p, out_flit[p]);
					release_at = cycle + int'($unsigned($random(seed)) % 7); // 0..6 later
					if (due[slot].size() > 0 && due[slot][$] >= release_at)
						release_at = due[slot][$] + 1; // one pulse per cycle
					due[slot].push_back(release_at);
					if (withholding(p, cycle))
					begin
						rx_stalled[slot]++;
						if (rx_stalled[slot] > BUFFER_DEPTH)
							check_value("flits during credit stall", BUFFER_DEPTH,
								rx_stalled[slot]);
					end
				end
			end
			if (cpu_valid)
				take_flit(3, cpu_flit);
			#1;
			cycle++;
			for (int p = 0; p < NUM_RING_PORTS; p++)
			begin
				for (int v = 0; v < NUM_VC; v++)
				begin
					slot = p * NUM_VC + v;
					if (withholding(p, cycle) && !withholding(p, cycle - 1))
						rx_stalled[slot] = 0; // new stall phase
					out_credit[p][v] = !withholding(p, cycle) && due[slot].size() > 0 &&
						due[slot][0] <= cycle;
					if (out_credit[p][v])
						due[slot].delete(0);
				end
			end
		end
	end

	initial
	begin : watchdog
		repeat (LIMIT) @(posedge clk);
		$display("timeout: flits still missing after %0d cycles", LIMIT);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin : main
		reset = 1'b1;
		for (int p = 0; p < NUM_RING_PORTS; p++)
		begin
			in_flit[p] = '0;
			in_valid[p] = 1'b0;
		end
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) // quiet before the first input
		begin
			@(posedge clk);
			check_value("idle after reset", 0, 32'({out_valid[0], out_valid[1], out_valid[2],
				cpu_valid, in_credit[0], in_credit[1], in_credit[2]}));
		end
		fork
			run_source(0);
			run_source(1);
			run_source(2);
		join
		while (queued_flits() != 0) // drain, watchdog bounds it
			@(posedge clk);
		repeat (4) @(posedge clk); // last in_credit pulses trail the dequeue by one cycle
		for (int t = 0; t < NUM_TAGS; t++)
			check_value("credit return count", sent[t], returned[t]);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* sim.f */
verilog/noc_pkg.sv
verilog/switch_if.sv
verilog/vc_buffer_bank.sv
verilog/node_control.sv
verilog/output_channel.sv
verilog/spidergon_node.sv
dv/spidergon_node_assertions.sv
dv/spidergon_node_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spidergon_node_tb \
	-f sim.f --Mdir obj_dir -o spidergon_node_sim

./obj_dir/spidergon_node_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
	exit 0
else
	exit 1
fi
